//--- hdl/cmd_pkg.sv
// command offload package
// shared widths, command and response structs, AXI4-Lite channel structs and register map
`default_nettype none

package cmd_pkg;

    // command tag echoed back by the response, and the command payload
    typedef logic [7:0]  cmd_id_t;
    typedef logic [15:0] cmd_operand_t;
    // completed-command count, wraps around
    typedef logic [15:0] cmd_count_t;

    // cmd_id sits in the low byte so a register write maps straight onto the struct
    typedef struct packed {
        cmd_operand_t operand;
        cmd_id_t      cmd_id;
    } cmd_req_t;

    typedef struct packed {
        cmd_id_t cmd_id;
    } cmd_resp_t;

    typedef logic [7:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [3:0]  axil_strb_t;
    typedef logic [1:0]  axil_resp_code_t;

    localparam axil_resp_code_t RESP_OKAY   = 2'b00;
    localparam axil_resp_code_t RESP_SLVERR = 2'b10;

    localparam axil_addr_t REG_CTRL    = 8'h00;
    localparam axil_addr_t REG_CMD     = 8'h04;
    localparam axil_addr_t REG_STATUS  = 8'h08;
    localparam axil_addr_t REG_LAST_ID = 8'h0C;

    // aw and ar carry the same fields
    typedef struct packed {
        axil_addr_t addr;
        logic       valid;
    } axil_ax_t;

    typedef struct packed {
        axil_data_t data;
        axil_strb_t strb;
        logic       valid;
    } axil_w_t;

    typedef struct packed {
        axil_resp_code_t resp;
        logic            valid;
    } axil_b_t;

    typedef struct packed {
        axil_data_t      data;
        axil_resp_code_t resp;
        logic            valid;
    } axil_r_t;

    // channels driven by the master
    typedef struct packed {
        axil_ax_t aw;
        axil_w_t  w;
        logic     b_ready;
        axil_ax_t ar;
        logic     r_ready;
    } axil_req_t;

    // channels driven by the slave
    typedef struct packed {
        logic    aw_ready;
        logic    w_ready;
        axil_b_t b;
        logic    ar_ready;
        axil_r_t r;
    } axil_resp_t;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        STALL
    } dispatch_state_e;

endpackage

`default_nettype wire

//--- hdl/cmd_fifo.sv
// synchronous FIFO for any packed type
// circular buffer with occupancy counter, reports full, empty and usage
`timescale 1ns/1ps
`default_nettype none

module cmd_fifo #(
    parameter int unsigned DEPTH = 4,
    parameter type         dtype = logic
) (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         push_i,
    input  dtype                         data_i,
    input  logic                         pop_i,
    output dtype                         data_o,
    output logic                         full_o,
    output logic                         empty_o,
    output logic [$clog2(DEPTH+1)-1:0]   usage_o
);

    // a single-entry buffer still needs a one-bit pointer
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    dtype             mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    // pointers wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);
    assign usage_o = count_q;

    // requests that would overflow or underflow are dropped here
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // head entry is always visible
    assign data_o = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            // push and pop together leave the occupancy as it is
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

`default_nettype wire

//--- hdl/cmd_sink.sv
// command sink
// buffers one response per accepted command and releases the head after a fixed delay
`timescale 1ns/1ps
`default_nettype none

module cmd_sink #(
    parameter int unsigned BUFF_SIZE = 4,
    parameter int unsigned LATENCY   = 10
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               cmd_valid_i,
    output logic               cmd_ready_o,
    input  cmd_pkg::cmd_req_t  cmd_i,
    output logic               cmd_resp_valid_o,
    output cmd_pkg::cmd_resp_t cmd_resp_o
);

    import cmd_pkg::*;

    // the timer is as wide as LATENCY needs, so it wraps every 2**TIMER_W cycles
    localparam int unsigned TIMER_W = (LATENCY > 1) ? $clog2(LATENCY) : 1;

    logic               resp_full;
    logic               resp_empty;
    logic               resp_pop;
    cmd_resp_t          new_resp;
    logic [TIMER_W-1:0] timer_q;

    // a response only echoes the command's tag
    assign new_resp.cmd_id = cmd_i.cmd_id;

    // ready drops as soon as the response buffer is full
    assign cmd_ready_o = !resp_full;

    // head leaves when the timer hits all ones
    assign resp_pop         = (&timer_q) && !resp_empty;
    assign cmd_resp_valid_o = resp_pop;

    cmd_fifo #(
        .DEPTH (BUFF_SIZE),
        .dtype (cmd_resp_t)
    ) resp_fifo_inst (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (cmd_valid_i && cmd_ready_o),
        .data_i  (new_resp),
        .pop_i   (resp_pop),
        .data_o  (cmd_resp_o),
        .full_o  (resp_full),
        .empty_o (resp_empty),
        .usage_o ()
    );

    // timer sits at zero while nothing is buffered and free-runs otherwise
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            timer_q <= '0;
        end else if (resp_empty) begin
            timer_q <= '0;
        end else begin
            timer_q <= timer_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/cmd_outstanding_counter.sv
// outstanding-command counter
// tracks commands in flight and completed commands, flags the in-flight limit
`timescale 1ns/1ps
`default_nettype none

module cmd_outstanding_counter #(
    parameter int unsigned MAX_OUTSTANDING = 6
) (
    input  logic                                   clk_i,
    input  logic                                   rst_ni,
    input  logic                                   issue_i,
    input  logic                                   complete_i,
    output logic [$clog2(MAX_OUTSTANDING+1)-1:0]   in_flight_o,
    output cmd_pkg::cmd_count_t                    completed_o,
    output logic                                   limit_o
);

    import cmd_pkg::*;

    localparam int unsigned CNT_W = $clog2(MAX_OUTSTANDING + 1);

    logic [CNT_W-1:0] in_flight_q;
    cmd_count_t       completed_q;

    assign in_flight_o = in_flight_q;
    assign completed_o = completed_q;

    // dispatcher holds off new commands while this is high
    assign limit_o = (in_flight_q == CNT_W'(MAX_OUTSTANDING));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            in_flight_q <= '0;
        end else begin
            // an issue and a completion in the same cycle cancel out
            case ({issue_i, complete_i})
                2'b10:   in_flight_q <= in_flight_q + 1'b1;
                2'b01:   in_flight_q <= in_flight_q - 1'b1;
                default: in_flight_q <= in_flight_q;
            endcase
        end
    end

    // completion count simply wraps, software takes differences
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            completed_q <= '0;
        end else if (complete_i) begin
            completed_q <= completed_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/cmd_dispatch_fsm.sv
// dispatch FSM
// moves commands from the host queue to the sink while enabled and credit remains
`timescale 1ns/1ps
`default_nettype none

module cmd_dispatch_fsm (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              enable_i,
    input  logic              queue_empty_i,
    input  cmd_pkg::cmd_req_t queue_data_i,
    output logic              queue_pop_o,
    input  logic              limit_i,
    output logic              cmd_valid_o,
    input  logic              cmd_ready_i,
    output cmd_pkg::cmd_req_t cmd_o,
    output logic              issue_o
);

    import cmd_pkg::*;

    dispatch_state_e state_q;
    dispatch_state_e state_d;
    cmd_req_t        cmd_q;
    logic            take;

    // a command can be taken when there is one, dispatch is on and credit is left
    assign take = enable_i && !queue_empty_i && !limit_i;

    always_comb begin
        state_d     = state_q;
        queue_pop_o = 1'b0;
        case (state_q)
            IDLE: begin
                if (take) begin
                    queue_pop_o = 1'b1;
                    state_d     = ISSUE;
                end else if (enable_i && !queue_empty_i) begin
                    // work is waiting but the in-flight limit is reached
                    state_d = STALL;
                end
            end
            ISSUE: begin
                if (cmd_ready_i) begin
                    state_d = IDLE;
                end
            end
            STALL: begin
                if (take) begin
                    queue_pop_o = 1'b1;
                    state_d     = ISSUE;
                end else if (!limit_i) begin
                    // credit came back but the queue drained or dispatch was paused
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // valid stays up with stable data until the sink takes it
    assign cmd_valid_o = (state_q == ISSUE);
    assign cmd_o       = cmd_q;
    assign issue_o     = cmd_valid_o && cmd_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // head command is latched as it is popped
    always_ff @(posedge clk_i) begin
        if (queue_pop_o) begin
            cmd_q <= queue_data_i;
        end
    end

endmodule

`default_nettype wire

//--- hdl/cmd_axil_regs.sv
// AXI4-Lite register block
// control, command push, status and last completed id, each access gets a registered response
`timescale 1ns/1ps
`default_nettype none

module cmd_axil_regs #(
    parameter int unsigned QUEUE_DEPTH     = 4,
    parameter int unsigned MAX_OUTSTANDING = 6
) (
    input  logic                                   clk_i,
    input  logic                                   rst_ni,
    input  cmd_pkg::axil_req_t                     axil_req_i,
    output cmd_pkg::axil_resp_t                    axil_resp_o,
    output logic                                   enable_o,
    output logic                                   push_o,
    output cmd_pkg::cmd_req_t                      push_data_o,
    input  logic                                   queue_full_i,
    input  logic [$clog2(QUEUE_DEPTH+1)-1:0]       queue_usage_i,
    input  logic [$clog2(MAX_OUTSTANDING+1)-1:0]   in_flight_i,
    input  cmd_pkg::cmd_count_t                    completed_i,
    input  logic                                   resp_valid_i,
    input  cmd_pkg::cmd_resp_t                     resp_i
);

    import cmd_pkg::*;

    logic            wr_ready;
    logic            wr_hs;
    logic            rd_ready;
    logic            rd_hs;
    axil_resp_code_t wr_resp;
    axil_resp_code_t rd_resp;
    axil_data_t      rd_data;
    axil_data_t      status_word;

    logic            ctrl_q;
    cmd_id_t         last_id_q;
    logic            b_valid_q;
    axil_resp_code_t b_resp_q;
    logic            r_valid_q;
    axil_resp_code_t r_resp_q;
    axil_data_t      r_data_q;

    // address and data are taken together, and only once the previous B is gone
    assign wr_ready = axil_req_i.aw.valid && axil_req_i.w.valid && !b_valid_q;
    assign wr_hs    = wr_ready;
    assign rd_ready = !r_valid_q;
    assign rd_hs    = axil_req_i.ar.valid && rd_ready;

    // a command write pushes straight into the host queue unless it is full
    assign push_o      = wr_hs && (axil_req_i.aw.addr == REG_CMD) && !queue_full_i;
    assign push_data_o = cmd_req_t'(axil_req_i.w.data[23:0]);
    assign enable_o    = ctrl_q;

    // completed count, in-flight count and queue usage packed side by side
    always_comb begin
        status_word        = '0;
        status_word[15:0]  = completed_i;
        status_word[23:16] = 8'(in_flight_i);
        status_word[27:24] = 4'(queue_usage_i);
    end

    // write strobes are ignored, every register is written whole
    always_comb begin
        case (axil_req_i.aw.addr)
            REG_CTRL, REG_STATUS, REG_LAST_ID: wr_resp = RESP_OKAY;
            REG_CMD: wr_resp = queue_full_i ? RESP_SLVERR : RESP_OKAY;
            default: wr_resp = RESP_SLVERR;
        endcase
    end

    always_comb begin
        rd_data = '0;
        rd_resp = RESP_OKAY;
        case (axil_req_i.ar.addr)
            REG_CTRL:    rd_data[0] = ctrl_q;
            REG_CMD:     rd_data = '0;
            REG_STATUS:  rd_data = status_word;
            REG_LAST_ID: rd_data[7:0] = last_id_q;
            default:     rd_resp = RESP_SLVERR;
        endcase
    end

    always_comb begin
        axil_resp_o          = '0;
        axil_resp_o.aw_ready = wr_ready;
        axil_resp_o.w_ready  = wr_ready;
        axil_resp_o.b.valid  = b_valid_q;
        axil_resp_o.b.resp   = b_resp_q;
        axil_resp_o.ar_ready = rd_ready;
        axil_resp_o.r.valid  = r_valid_q;
        axil_resp_o.r.resp   = r_resp_q;
        axil_resp_o.r.data   = r_data_q;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ctrl_q    <= 1'b0;
            last_id_q <= '0;
            b_valid_q <= 1'b0;
            r_valid_q <= 1'b0;
        end else begin
            if (wr_hs && (axil_req_i.aw.addr == REG_CTRL)) begin
                ctrl_q <= axil_req_i.w.data[0];
            end
            // last id follows every response the sink releases
            if (resp_valid_i) begin
                last_id_q <= resp_i.cmd_id;
            end
            // B and R stay up until the master takes them
            if (wr_hs) begin
                b_valid_q <= 1'b1;
            end else if (axil_req_i.b_ready) begin
                b_valid_q <= 1'b0;
            end
            if (rd_hs) begin
                r_valid_q <= 1'b1;
            end else if (axil_req_i.r_ready) begin
                r_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_hs) begin
            b_resp_q <= wr_resp;
        end
        if (rd_hs) begin
            r_resp_q <= rd_resp;
            r_data_q <= rd_data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/cmd_offload_top.sv
// command offload top level
// register block, host queue, dispatcher, outstanding counter and command sink
`timescale 1ns/1ps
`default_nettype none

module cmd_offload_top #(
    parameter int unsigned QUEUE_DEPTH     = 4,
    parameter int unsigned SINK_DEPTH      = 4,
    parameter int unsigned MAX_OUTSTANDING = 6,
    parameter int unsigned LATENCY         = 10
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  cmd_pkg::axil_req_t  axil_req_i,
    output cmd_pkg::axil_resp_t axil_resp_o
);

    import cmd_pkg::*;

    // host queue side
    logic                                 push;
    cmd_req_t                             push_data;
    logic                                 queue_pop;
    cmd_req_t                             queue_data;
    logic                                 queue_full;
    logic                                 queue_empty;
    logic [$clog2(QUEUE_DEPTH+1)-1:0]     queue_usage;

    // dispatch and credit
    logic                                 dispatch_en;
    logic                                 limit;
    logic                                 issue;
    logic [$clog2(MAX_OUTSTANDING+1)-1:0] in_flight;
    cmd_count_t                           completed;

    // sink side
    logic                                 cmd_valid;
    logic                                 cmd_ready;
    cmd_req_t                             sink_cmd;
    logic                                 resp_valid;
    cmd_resp_t                            resp;

    cmd_axil_regs #(
        .QUEUE_DEPTH     (QUEUE_DEPTH),
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) cmd_axil_regs_inst (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .axil_req_i    (axil_req_i),
        .axil_resp_o   (axil_resp_o),
        .enable_o      (dispatch_en),
        .push_o        (push),
        .push_data_o   (push_data),
        .queue_full_i  (queue_full),
        .queue_usage_i (queue_usage),
        .in_flight_i   (in_flight),
        .completed_i   (completed),
        .resp_valid_i  (resp_valid),
        .resp_i        (resp)
    );

    cmd_fifo #(
        .DEPTH (QUEUE_DEPTH),
        .dtype (cmd_req_t)
    ) host_queue_inst (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (push),
        .data_i  (push_data),
        .pop_i   (queue_pop),
        .data_o  (queue_data),
        .full_o  (queue_full),
        .empty_o (queue_empty),
        .usage_o (queue_usage)
    );

    cmd_dispatch_fsm cmd_dispatch_fsm_inst (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .enable_i      (dispatch_en),
        .queue_empty_i (queue_empty),
        .queue_data_i  (queue_data),
        .queue_pop_o   (queue_pop),
        .limit_i       (limit),
        .cmd_valid_o   (cmd_valid),
        .cmd_ready_i   (cmd_ready),
        .cmd_o         (sink_cmd),
        .issue_o       (issue)
    );

    cmd_outstanding_counter #(
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) cmd_outstanding_counter_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .issue_i     (issue),
        .complete_i  (resp_valid),
        .in_flight_o (in_flight),
        .completed_o (completed),
        .limit_o     (limit)
    );

    cmd_sink #(
        .BUFF_SIZE (SINK_DEPTH),
        .LATENCY   (LATENCY)
    ) cmd_sink_inst (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .cmd_valid_i      (cmd_valid),
        .cmd_ready_o      (cmd_ready),
        .cmd_i            (sink_cmd),
        .cmd_resp_valid_o (resp_valid),
        .cmd_resp_o       (resp)
    );

endmodule

`default_nettype wire

//--- verif/tb_cmd_offload.sv
// testbench for the command offload subsystem
// drives AXI4-Lite accesses with random commands and checks them against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_cmd_offload;

    import cmd_pkg::*;

    localparam int unsigned QUEUE_DEPTH     = 4;
    localparam int unsigned SINK_DEPTH      = 4;
    // a limit below the sink depth makes the dispatcher stall on credit
    localparam int unsigned MAX_OUTSTANDING = 3;
    localparam int unsigned LATENCY         = 10;
    localparam int unsigned NUM_BURSTS      = 8;
    localparam int unsigned MAX_BURST       = 8;
    localparam int unsigned PAUSE_CMDS      = 10;
    // every command attempt may cost one full release interval per in-flight slot
    localparam int unsigned NUM_CMDS        = QUEUE_DEPTH + 1 + NUM_BURSTS * MAX_BURST + PAUSE_CMDS;
    localparam int unsigned WATCHDOG_CYCLES = NUM_CMDS * 16 * MAX_OUTSTANDING + 2000;

    logic       clk_i = 1'b0;
    logic       rst_ni;
    axil_req_t  axil_req;
    axil_resp_t axil_resp;

    // reference model state
    int           seed = 13424;
    cmd_id_t      accepted_q[$];
    int unsigned  accepted_cnt;
    int unsigned  model_completed;
    cmd_id_t      exp_last_id;

    always #5 clk_i = ~clk_i;

    cmd_offload_top #(
        .QUEUE_DEPTH     (QUEUE_DEPTH),
        .SINK_DEPTH      (SINK_DEPTH),
        .MAX_OUTSTANDING (MAX_OUTSTANDING),
        .LATENCY         (LATENCY)
    ) cmd_offload_top_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .axil_req_i  (axil_req),
        .axil_resp_o (axil_resp)
    );

    task automatic check(input string name, input logic [31:0] actual, input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic wait_cycles(input int unsigned n);
        repeat (n) @(negedge clk_i);
    endtask

    // address and data go out together, ready is sampled 1 ns after the falling edge
    task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                              output axil_resp_code_t resp);
        @(negedge clk_i);
        axil_req.aw.addr  = addr;
        axil_req.aw.valid = 1'b1;
        axil_req.w.data   = data;
        axil_req.w.strb   = '1;
        axil_req.w.valid  = 1'b1;
        #1;
        while (!axil_resp.aw_ready) begin
            @(negedge clk_i);
            #1;
        end
        @(negedge clk_i);
        axil_req.aw.valid = 1'b0;
        axil_req.w.valid  = 1'b0;
        axil_req.b_ready  = 1'b1;
        #1;
        while (!axil_resp.b.valid) begin
            @(negedge clk_i);
            #1;
        end
        resp = axil_resp.b.resp;
        @(negedge clk_i);
        axil_req.b_ready = 1'b0;
    endtask

    task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                             output axil_resp_code_t resp);
        @(negedge clk_i);
        axil_req.ar.addr  = addr;
        axil_req.ar.valid = 1'b1;
        #1;
        while (!axil_resp.ar_ready) begin
            @(negedge clk_i);
            #1;
        end
        @(negedge clk_i);
        axil_req.ar.valid = 1'b0;
        axil_req.r_ready  = 1'b1;
        #1;
        while (!axil_resp.r.valid) begin
            @(negedge clk_i);
            #1;
        end
        data = axil_resp.r.data;
        resp = axil_resp.r.resp;
        @(negedge clk_i);
        axil_req.r_ready = 1'b0;
    endtask

    // a random command goes to REG_CMD, the model only keeps the ones that got OKAY
    task automatic send_cmd(output axil_resp_code_t resp);
        cmd_id_t      id;
        cmd_operand_t operand;
        id      = cmd_id_t'($random(seed));
        operand = cmd_operand_t'($random(seed));
        axil_write(REG_CMD, {8'h00, operand, id}, resp);
        // the queue cannot be full while fewer than QUEUE_DEPTH commands are unaccounted for
        if (accepted_cnt - model_completed < QUEUE_DEPTH) begin
            check("CMD.bresp", resp, RESP_OKAY);
        end
        if (resp == RESP_OKAY) begin
            accepted_q.push_back(id);
            accepted_cnt++;
        end
    endtask

    // reads STATUS, checks the credit limit and conservation, then retires completed ids
    task automatic poll_status(output int unsigned completed, output int unsigned in_flight,
                               output int unsigned usage);
        axil_data_t      data;
        axil_resp_code_t resp;
        int unsigned     sum;
        axil_read(REG_STATUS, data, resp);
        check("STATUS.rresp", resp, RESP_OKAY);
        completed = data[15:0];
        in_flight = data[23:16];
        usage     = data[27:24];
        check("STATUS.in_flight", in_flight,
              (in_flight > MAX_OUTSTANDING) ? MAX_OUTSTANDING : in_flight);
        // one command may sit in the dispatcher between its pop and the sink handshake
        sum = completed + in_flight + usage;
        check("STATUS.sum", sum, (sum + 1 == accepted_cnt) ? sum : accepted_cnt);
        // responses leave in issue order, so the newest completion is the last one retired
        while (model_completed < completed) begin
            exp_last_id = accepted_q.pop_front();
            model_completed++;
        end
    endtask

    task automatic drain_and_check();
        int unsigned     c;
        int unsigned     f;
        int unsigned     u;
        axil_data_t      data;
        axil_resp_code_t resp;
        do begin
            poll_status(c, f, u);
        end while (c != accepted_cnt);
        check("STATUS.in_flight", f, 0);
        check("STATUS.usage", u, 0);
        axil_read(REG_LAST_ID, data, resp);
        check("LAST_ID.rresp", resp, RESP_OKAY);
        check("LAST_ID", data, {24'h0, exp_last_id});
    endtask

    // ends the run if the DUT stops answering
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        axil_data_t      data;
        axil_data_t      snap;
        axil_resp_code_t resp;
        axil_addr_t      bad_addr;
        int unsigned     c;
        int unsigned     f;
        int unsigned     u;
        int unsigned     snap_c;
        int unsigned     snap_u;
        int unsigned     len;
        axil_req        = '0;
        rst_ni          = 1'b0;
        accepted_cnt    = 0;
        model_completed = 0;
        exp_last_id     = '0;
        wait_cycles(8);
        rst_ni = 1'b1;

        // every register is zero after reset
        for (int a = 0; a < 4; a++) begin
            axil_read(axil_addr_t'(a * 4), data, resp);
            check("reset.rresp", resp, RESP_OKAY);
            check("reset.rdata", data, 0);
        end

        // dispatch is off, so the host queue fills and the next push is refused
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            send_cmd(resp);
            check("CMD.bresp (queue not full)", resp, RESP_OKAY);
        end
        send_cmd(resp);
        check("CMD.bresp (queue full)", resp, RESP_SLVERR);
        for (int pass = 0; pass < 2; pass++) begin
            poll_status(c, f, u);
            check("STATUS.usage (disabled)", u, QUEUE_DEPTH);
            check("STATUS.in_flight (disabled)", f, 0);
            check("STATUS.completed (disabled)", c, 0);
            wait_cycles(120);
        end

        // enabling dispatch drains everything in order
        axil_write(REG_CTRL, 32'h1, resp);
        check("CTRL.bresp", resp, RESP_OKAY);
        axil_read(REG_CTRL, data, resp);
        check("CTRL", data, 32'h1);
        drain_and_check();

        // random bursts, every status poll checks the limit and the conservation rule
        for (int b = 0; b < NUM_BURSTS; b++) begin
            len = 1 + ($unsigned($random(seed)) % MAX_BURST);
            for (int i = 0; i < len; i++) begin
                send_cmd(resp);
                poll_status(c, f, u);
            end
        end
        drain_and_check();

        // pausing mid-run stops dispatch but keeps the queued commands
        for (int i = 0; i < PAUSE_CMDS; i++) begin
            send_cmd(resp);
        end
        axil_write(REG_CTRL, 32'h0, resp);
        check("CTRL.bresp", resp, RESP_OKAY);
        do begin
            poll_status(c, f, u);
        end while (f != 0 || c + u != accepted_cnt);
        snap_c = c;
        snap_u = u;
        wait_cycles(150);
        poll_status(c, f, u);
        check("STATUS.completed (paused)", c, snap_c);
        check("STATUS.in_flight (paused)", f, 0);
        check("STATUS.usage (paused)", u, snap_u);
        axil_write(REG_CTRL, 32'h1, resp);
        drain_and_check();

        // unmapped offsets answer SLVERR and read as zero
        for (int k = 0; k < 4; k++) begin
            // the last offset is also misaligned
            bad_addr = 8'h10 + 8'(k * 4) + ((k == 3) ? 8'h01 : 8'h00);
            axil_write(bad_addr, 32'hDEAD_BEEF, resp);
            check("unmapped.bresp", resp, RESP_SLVERR);
            axil_read(bad_addr, snap, resp);
            check("unmapped.rresp", resp, RESP_SLVERR);
            check("unmapped.rdata", snap, 0);
        end
        // STATUS is read only, a write to it is acknowledged and ignored
        axil_read(REG_STATUS, snap, resp);
        axil_write(REG_STATUS, $random(seed), resp);
        check("STATUS.bresp", resp, RESP_OKAY);
        axil_read(REG_STATUS, data, resp);
        check("STATUS (after write)", data, snap);

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
hdl/cmd_pkg.sv
hdl/cmd_fifo.sv
hdl/cmd_sink.sv
hdl/cmd_outstanding_counter.sv
hdl/cmd_dispatch_fsm.sv
hdl/cmd_axil_regs.sv
hdl/cmd_offload_top.sv
verif/tb_cmd_offload.sv

//--- Bender.yml
package:
  name: cmd_offload

sources:
  # RTL in compile order
  - files:
      - hdl/cmd_pkg.sv
      - hdl/cmd_fifo.sv
      - hdl/cmd_sink.sv
      - hdl/cmd_outstanding_counter.sv
      - hdl/cmd_dispatch_fsm.sv
      - hdl/cmd_axil_regs.sv
      - hdl/cmd_offload_top.sv
  # testbench
  - target: test
    files:
      - verif/tb_cmd_offload.sv
